//--- flist.f
hdl/raster_pkg.sv
hdl/bounding_box.sv
hdl/edge_setup.sv
hdl/edge_mask.sv
hdl/patch_walker.sv
hdl/raster_regs.sv
hdl/raster_top.sv
test/raster_properties.sv
test/raster_tb.sv

//--- run.sh
#!/bin/sh
# build the raster testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module raster_tb -f flist.f -o raster_sim

# the log decides the result, so a stopped simulation must not end the script here
./obj_dir/raster_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "run.sh: failure reported in sim.log"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "run.sh: simulation ended without a result"
    exit 1
fi

//--- test/raster_tb.sv
// raster testbench: table of triangles run through the DUT and a coverage model
`timescale 1ns/1ns
`default_nettype none

module raster_tb import raster_pkg::*; ();

    localparam int DRIVE_DELAY    = 2;
    localparam int SAMPLE_DELAY   = 20;
    localparam int BUS_TIMEOUT    = 16;
    localparam int STATUS_TIMEOUT = 2000;
    localparam int NUM_ROWS       = 6;

    // shared keeps the coverage map of the row before
    typedef struct packed {
        int tile_x;
        int tile_y;
        int x1;
        int y1;
        int x2;
        int y2;
        int x3;
        int y3;
        int patches;
        int bits;
        bit shared;
    } row_t;

    logic              clock;
    logic              reset;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADR_W-1:0]  adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;

    row_t        table_rows [0:NUM_ROWS-1];
    // model output for the current row in row-major order
    int          exp_px [$];
    int          exp_py [$];
    logic [15:0] exp_mask [$];
    // covered samples per patch as [row][col] inside the tile
    logic [15:0] cover_map [0:15][0:15];

    raster_top dut0 (
        .clock (clock),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #20 clock = ~clock;

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
            stop_run();
        end
    endtask

    // one wishbone classic cycle with stb held until the edge after ack
    task automatic bus_access(input bit write, input reg_addr_t which,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        @(posedge clock);
        #DRIVE_DELAY;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = {which, 2'b00};
        dat_w = wdata;
        @(posedge clock);
        #SAMPLE_DELAY;
        while (!ack) begin
            cycles++;
            if (cycles > BUS_TIMEOUT) begin
                $display("timeout: no ack on the bus at %0t ns", $time);
                stop_run();
            end
            @(posedge clock);
            #SAMPLE_DELAY;
        end
        rdata = dat_r;
        @(posedge clock);
        #DRIVE_DELAY;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    // held mask or end of walk
    task automatic wait_for_status(output bit finished);
        int cycles;
        cycles = 0;
        while (!(dut0.mask_valid || dut0.done)) begin
            cycles++;
            if (cycles > STATUS_TIMEOUT) begin
                $display("timeout: neither mask_valid nor done at %0t ns", $time);
                stop_run();
            end
            @(posedge clock);
            #SAMPLE_DELAY;
        end
        finished = dut0.done;
    endtask

    // clamped min and max patch on one axis relative to the tile
    function automatic void patch_range(input int tile, input int v1, input int v2,
                                        input int v3, output int lo, output int hi);
        int vmin;
        int vmax;
        vmin = (v2 < v1) ? v2 : v1;
        vmin = (v3 < vmin) ? v3 : vmin;
        vmax = (v2 > v1) ? v2 : v1;
        vmax = (v3 > vmax) ? v3 : vmax;
        lo = (vmin >>> 2) - tile * 16;
        hi = (vmax >>> 2) - tile * 16;
        lo = (lo < 0) ? 0 : ((lo > 15) ? 15 : lo);
        hi = (hi < 0) ? 0 : ((hi > 15) ? 15 : hi);
    endfunction

    // samples where all edges of a*x - b*y + c are not negative
    function automatic logic [15:0] model_mask(input row_t r, input int px, input int py);
        longint      vx [0:2];
        longint      vy [0:2];
        longint      a;
        longint      b;
        longint      c;
        longint      x;
        longint      y;
        int          j;
        logic [15:0] m;
        vx[0] = r.x1;
        vy[0] = r.y1;
        vx[1] = r.x2;
        vy[1] = r.y2;
        vx[2] = r.x3;
        vy[2] = r.y3;
        m = 16'hffff;
        for (int e = 0; e < 3; e++) begin
            j = (e + 1) % 3;
            a = vy[j] - vy[e];
            b = vx[j] - vx[e];
            c = b * vy[e] - a * vx[e];
            // tie break on shared edges
            if (vy[e] < vy[j] || (vy[e] == vy[j] && vx[j] < vx[e]))
                c = c - 1;
            for (int s = 0; s < 16; s++) begin
                x = r.tile_x * 64 + px * 4 + s % 4;
                y = r.tile_y * 64 + py * 4 + s / 4;
                if (a * x - b * y + c < 0)
                    m[15 - s] = 1'b0;
            end
        end
        return m;
    endfunction

    task automatic build_expectations(input row_t r, input int index);
        int          x_lo;
        int          x_hi;
        int          y_lo;
        int          y_hi;
        logic [15:0] m;
        exp_px.delete();
        exp_py.delete();
        exp_mask.delete();
        patch_range(r.tile_x, r.x1, r.x2, r.x3, x_lo, x_hi);
        patch_range(r.tile_y, r.y1, r.y2, r.y3, y_lo, y_hi);
        for (int py = y_lo; py <= y_hi; py++) begin
            for (int px = x_lo; px <= x_hi; px++) begin
                m = model_mask(r, px, py);
                if (m != 16'h0000) begin
                    exp_px.push_back(px);
                    exp_py.push_back(py);
                    exp_mask.push_back(m);
                end
            end
        end
        check_value(exp_mask.size(), r.patches, $sformatf("row %0d model patch count", index));
    endtask

    function automatic int map_bits();
        int total;
        total = 0;
        for (int py = 0; py < 16; py++)
            for (int px = 0; px < 16; px++)
                total += $countones(cover_map[py][px]);
        return total;
    endfunction

    task automatic run_row(input row_t r, input int index);
        logic [31:0] rdata;
        logic [31:0] pos;
        bit          finished;
        int          seen;
        int          px;
        int          py;
        if (!r.shared) begin
            for (int i = 0; i < 256; i++)
                cover_map[i / 16][i % 16] = 16'h0000;
        end
        build_expectations(r, index);
        bus_access(1'b1, REG_TILE, {r.tile_y[9:0], 6'd0, r.tile_x[9:0], 6'd0}, rdata);
        bus_access(1'b1, REG_V1, {r.y1[15:0], r.x1[15:0]}, rdata);
        bus_access(1'b1, REG_V2, {r.y2[15:0], r.x2[15:0]}, rdata);
        bus_access(1'b1, REG_V3, {r.y3[15:0], r.x3[15:0]}, rdata);
        // tile fields read back before the walk
        bus_access(1'b0, REG_TILE, 32'h0, pos);
        check_value(pos[31:22], r.tile_y[9:0], $sformatf("row %0d tile_y readback", index));
        check_value(pos[15:6], r.tile_x[9:0], $sformatf("row %0d tile_x readback", index));
        bus_access(1'b1, REG_CTRL, 32'h0, rdata);
        seen = 0;
        wait_for_status(finished);
        while (!finished) begin
            // position first since the status read releases the patch
            bus_access(1'b0, REG_TILE, 32'h0, pos);
            bus_access(1'b0, REG_CTRL, 32'h0, rdata);
            px = pos[5:2];
            py = pos[21:18];
            check_value(exp_mask.size() > 0, 1, $sformatf("row %0d mask past model list", index));
            check_value(pos[31:22], r.tile_y[9:0], $sformatf("row %0d patch tile_y", index));
            check_value(pos[15:6], r.tile_x[9:0], $sformatf("row %0d patch tile_x", index));
            check_value(px, exp_px[0], $sformatf("row %0d patch %0d column", index, seen));
            check_value(py, exp_py[0], $sformatf("row %0d patch %0d row", index, seen));
            check_value(rdata[VALID_BIT], 1'b1, $sformatf("row %0d mask_valid", index));
            check_value(rdata[DONE_BIT], 1'b0, $sformatf("row %0d done during walk", index));
            check_value(rdata[15:0], exp_mask[0], $sformatf("row %0d patch %0d mask", index, seen));
            check_value(cover_map[py][px] & rdata[15:0], 16'h0000,
                        $sformatf("row %0d overlap at patch %0d", index, seen));
            cover_map[py][px] = cover_map[py][px] | rdata[15:0];
            void'(exp_px.pop_front());
            void'(exp_py.pop_front());
            void'(exp_mask.pop_front());
            seen++;
            wait_for_status(finished);
        end
        check_value(seen, r.patches, $sformatf("row %0d patch count", index));
        check_value(exp_mask.size(), 0, $sformatf("row %0d masks left in model", index));
        bus_access(1'b0, REG_CTRL, 32'h0, rdata);
        check_value(rdata[DONE_BIT], 1'b1, $sformatf("row %0d done at end", index));
        check_value(rdata[VALID_BIT], 1'b0, $sformatf("row %0d mask_valid at end", index));
        // union of both triangles when shared
        check_value(map_bits(), r.bits, $sformatf("row %0d covered samples", index));
    endtask

    initial begin
        logic [31:0] status;
        clock      = 1'b0;
        reset      = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;

        // tile, v1, v2, v3, patches, samples, shared
        table_rows[0] = '{0, 0, 0, 0, 0, 16, 16, 0, 13, 120, 1'b0};
        // shares the edge between (0,16) and (16,0) with row 0
        table_rows[1] = '{0, 0, 0, 16, 16, 16, 16, 0, 19, 256, 1'b1};
        // clockwise
        table_rows[2] = '{0, 0, 0, 0, 16, 0, 0, 16, 0, 0, 1'b0};
        // collinear
        table_rows[3] = '{0, 0, 8, 8, 24, 8, 40, 8, 0, 0, 1'b0};
        // crosses the tile's left and bottom borders
        table_rows[4] = '{1, 0, 0, 0, 0, 96, 96, 0, 44, 528, 1'b0};
        // covers the whole tile
        table_rows[5] = '{1, 1, 0, 0, 0, 400, 400, 0, 256, 4096, 1'b0};

        repeat (8) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        // idle state after reset
        bus_access(1'b0, REG_CTRL, 32'h0, status);
        check_value(status[DONE_BIT], 1'b1, "done after reset");
        check_value(status[VALID_BIT], 1'b0, "mask_valid after reset");

        for (int i = 0; i < NUM_ROWS; i++)
            run_row(table_rows[i], i);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/raster_properties.sv
// raster properties: wishbone ack and walker status checks on the register block
`timescale 1ns/1ns
`default_nettype none

module raster_properties (
    input logic clock,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic mask_valid,
    input logic done
);

    // ack only inside an active bus cycle
    ack_in_cycle: assert property (@(posedge clock) disable iff (reset) ack |-> (cyc && stb))
        else $error("ack seen without cyc and stb");

    // single cycle ack
    ack_single: assert property (@(posedge clock) disable iff (reset) ack |=> !ack)
        else $error("ack high for two cycles in a row");

    // a held mask means the walk is still running
    status_excl: assert property (@(posedge clock) disable iff (reset) !(mask_valid && done))
        else $error("mask_valid and done high together");

endmodule

bind raster_regs raster_properties u_props (
    .clock      (clock),
    .reset      (reset),
    .cyc        (cyc),
    .stb        (stb),
    .ack        (ack),
    .mask_valid (mask_valid),
    .done       (done)
);

`default_nettype wire

//--- hdl/raster_top.sv
// raster top: wishbone register block driving the patch walker
`timescale 1ns/1ns
`default_nettype none

module raster_top import raster_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [ADR_W-1:0]  adr,
    input  logic [DATA_W-1:0] dat_w,
    output logic [DATA_W-1:0] dat_r,
    output logic              ack
);

    // triangle setup from the host
    tile_idx_t   tile_x;
    tile_idx_t   tile_y;
    coord_t      x1;
    coord_t      y1;
    coord_t      x2;
    coord_t      y2;
    coord_t      x3;
    coord_t      y3;
    logic        start;
    logic        mask_release;
    // walker status back to the host
    patch_idx_t  patch_x;
    patch_idx_t  patch_y;
    patch_mask_t mask;
    logic        mask_valid;
    logic        done;

    raster_regs u_regs (
        .clock        (clock),
        .reset        (reset),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .patch_x      (patch_x),
        .patch_y      (patch_y),
        .mask         (mask),
        .mask_valid   (mask_valid),
        .done         (done),
        .dat_r        (dat_r),
        .ack          (ack),
        .tile_x       (tile_x),
        .tile_y       (tile_y),
        .x1           (x1),
        .y1           (y1),
        .x2           (x2),
        .y2           (y2),
        .x3           (x3),
        .y3           (y3),
        .start        (start),
        .mask_release (mask_release)
    );

    patch_walker u_walker (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .mask_release (mask_release),
        .tile_x       (tile_x),
        .tile_y       (tile_y),
        .x1           (x1),
        .y1           (y1),
        .x2           (x2),
        .y2           (y2),
        .x3           (x3),
        .y3           (y3),
        .patch_x      (patch_x),
        .patch_y      (patch_y),
        .mask         (mask),
        .mask_valid   (mask_valid),
        .done         (done)
    );

endmodule

`default_nettype wire

//--- hdl/raster_regs.sv
// register block: wishbone classic slave for tile, vertices, start and mask release
`timescale 1ns/1ns
`default_nettype none

module raster_regs import raster_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [ADR_W-1:0]  adr,
    input  logic [DATA_W-1:0] dat_w,
    input  patch_idx_t        patch_x,
    input  patch_idx_t        patch_y,
    input  patch_mask_t       mask,
    input  logic              mask_valid,
    input  logic              done,
    output logic [DATA_W-1:0] dat_r,
    output logic              ack,
    output tile_idx_t         tile_x,
    output tile_idx_t         tile_y,
    output coord_t            x1,
    output coord_t            y1,
    output coord_t            x2,
    output coord_t            y2,
    output coord_t            x3,
    output coord_t            y3,
    output logic              start,
    output logic              mask_release
);

    reg_addr_t reg_sel;

    // byte address to word index
    assign reg_sel = adr[4:2];

    // one ack per cycle, dropped after a single clock
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= cyc && stb && !ack;
        end
    end

    // pulses follow ack, so each lasts one cycle
    assign start        = ack && we && (reg_sel == REG_CTRL);
    assign mask_release = ack && !we && (reg_sel == REG_CTRL);

    // tile and vertex storage, taken on the acknowledged write
    always_ff @(posedge clock) begin
        if (ack && we) begin
            case (reg_sel)
                REG_TILE: begin
                    tile_x <= dat_w[15:6];
                    tile_y <= dat_w[31:22];
                end
                REG_V1: begin
                    x1 <= dat_w[15:0];
                    y1 <= dat_w[31:16];
                end
                REG_V2: begin
                    x2 <= dat_w[15:0];
                    y2 <= dat_w[31:16];
                end
                REG_V3: begin
                    x3 <= dat_w[15:0];
                    y3 <= dat_w[31:16];
                end
                default: ;
            endcase
        end
    end

    // read mux, sampled by the master while ack is high
    always_comb begin
        dat_r = '0;
        case (reg_sel)
            REG_TILE: begin
                // current patch position in screen units
                dat_r[31:16] = {tile_y, patch_y, 2'b00};
                dat_r[15:0]  = {tile_x, patch_x, 2'b00};
            end
            REG_CTRL: begin
                dat_r[15:0]      = mask;
                dat_r[DONE_BIT]  = done;
                dat_r[VALID_BIT] = mask_valid;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/patch_walker.sv
// patch walker: box and edge setup, then row-major patch walk with mask hold
`timescale 1ns/1ns
`default_nettype none

module patch_walker import raster_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  logic        mask_release,
    input  tile_idx_t   tile_x,
    input  tile_idx_t   tile_y,
    input  coord_t      x1,
    input  coord_t      y1,
    input  coord_t      x2,
    input  coord_t      y2,
    input  coord_t      x3,
    input  coord_t      y3,
    output patch_idx_t  patch_x,
    output patch_idx_t  patch_y,
    output patch_mask_t mask,
    output logic        mask_valid,
    output logic        done
);

    typedef enum logic [2:0] {
        S_IDLE, S_BOX, S_SETUP, S_MASK, S_DECIDE, S_ADVANCE
    } state_t;

    state_t     state;
    // box: axis, setup: edge*2+phase, mask: edge
    logic [2:0] step;
    logic [1:0] sel;

    patch_idx_t left_r;
    patch_idx_t right_r;
    patch_idx_t top_r;
    patch_idx_t bot_r;

    // per-edge state, c holds the value at the row start
    edge_coef_t a_r [0:2];
    edge_coef_t b_r [0:2];
    edge_val_t  c_r [0:2];
    edge_val_t  d_r [0:2];

    tile_idx_t   box_tile;
    coord_t      box_v1;
    coord_t      box_v2;
    coord_t      box_v3;
    patch_idx_t  box_lo;
    patch_idx_t  box_hi;
    coord_t      su_x1;
    coord_t      su_y1;
    coord_t      su_x2;
    coord_t      su_y2;
    coord_t      corner_x;
    coord_t      corner_y;
    edge_coef_t  su_a;
    edge_coef_t  su_b;
    edge_val_t   su_cd;
    patch_mask_t edge_bits;
    patch_mask_t combined;
    edge_val_t   step_a;
    edge_val_t   step_b;
    logic        at_right;
    logic        at_bottom;

    assign sel = (state == S_SETUP) ? step[2:1] : step[1:0];

    // x axis on step 0, y axis on step 1
    always_comb begin
        if (step[0]) begin
            box_tile = tile_y;
            box_v1   = y1;
            box_v2   = y2;
            box_v3   = y3;
        end else begin
            box_tile = tile_x;
            box_v1   = x1;
            box_v2   = x2;
            box_v3   = x3;
        end
    end

    bounding_box u_box (
        .tile (box_tile),
        .v1   (box_v1),
        .v2   (box_v2),
        .v3   (box_v3),
        .lo   (box_lo),
        .hi   (box_hi)
    );

    // vertex pairs 1-2, 2-3, 3-1
    always_comb begin
        case (sel)
            2'd0: begin
                su_x1 = x1;
                su_y1 = y1;
                su_x2 = x2;
                su_y2 = y2;
            end
            2'd1: begin
                su_x1 = x2;
                su_y1 = y2;
                su_x2 = x3;
                su_y2 = y3;
            end
            default: begin
                su_x1 = x3;
                su_y1 = y3;
                su_x2 = x1;
                su_y2 = y1;
            end
        endcase
    end

    // top-left corner of the first patch in the box
    assign corner_x = {tile_x, left_r, 2'b00};
    assign corner_y = {tile_y, top_r, 2'b00};

    edge_setup u_setup (
        .corner_x (corner_x),
        .corner_y (corner_y),
        .x1       (su_x1),
        .y1       (su_y1),
        .x2       (su_x2),
        .y2       (su_y2),
        .c_in     (c_r[sel]),
        .phase    (step[0]),
        .a        (su_a),
        .b        (su_b),
        .cd       (su_cd)
    );

    edge_mask u_mask (
        .a    (a_r[sel]),
        .b    (b_r[sel]),
        .d    (d_r[sel]),
        .mask (edge_bits)
    );

    // and of all edges seen so far in this patch
    assign combined = (step[1:0] == 2'd0) ? edge_bits : (mask & edge_bits);

    // one patch step is 4 units
    assign step_a = edge_val_t'(a_r[sel]) <<< 2;
    assign step_b = edge_val_t'(b_r[sel]) <<< 2;

    assign at_right  = patch_x >= right_r;
    assign at_bottom = patch_y >= bot_r;

    // box limits, edge terms and the mask
    always_ff @(posedge clock) begin
        case (state)
            S_BOX: begin
                if (!step[0]) begin
                    left_r  <= box_lo;
                    right_r <= box_hi;
                end else begin
                    top_r <= box_lo;
                    bot_r <= box_hi;
                end
            end
            S_SETUP: begin
                c_r[sel] <= su_cd;
                if (!step[0]) begin
                    a_r[sel] <= su_a;
                    b_r[sel] <= su_b;
                end else begin
                    d_r[sel] <= su_cd;
                end
            end
            S_MASK: begin
                mask <= combined;
                // next row starts 4 units down, else step right
                if (at_right) begin
                    c_r[sel] <= c_r[sel] - step_b;
                    d_r[sel] <= c_r[sel] - step_b;
                end else begin
                    d_r[sel] <= d_r[sel] + step_a;
                end
            end
            default: ;
        endcase
    end

    // sequencer and patch position
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= S_IDLE;
            step       <= 3'd0;
            done       <= 1'b1;
            mask_valid <= 1'b0;
            patch_x    <= '0;
            patch_y    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_BOX;
                        step  <= 3'd0;
                        done  <= 1'b0;
                    end
                end
                S_BOX: begin
                    if (step == 3'd1) begin
                        state <= S_SETUP;
                        step  <= 3'd0;
                    end else begin
                        step <= step + 3'd1;
                    end
                end
                S_SETUP: begin
                    // box limits are ready by now
                    if (step == 3'd0) begin
                        patch_x <= left_r;
                        patch_y <= top_r;
                    end
                    if (step == 3'd5) begin
                        state <= S_MASK;
                        step  <= 3'd0;
                    end else begin
                        step <= step + 3'd1;
                    end
                end
                S_MASK: begin
                    if (step == 3'd2) begin
                        state      <= S_DECIDE;
                        step       <= 3'd0;
                        mask_valid <= |combined;
                    end else begin
                        step <= step + 3'd1;
                    end
                end
                S_DECIDE: begin
                    // empty mask moves on, full one waits for the host
                    if (!mask_valid || mask_release) begin
                        state      <= S_ADVANCE;
                        mask_valid <= 1'b0;
                    end
                end
                S_ADVANCE: begin
                    if (at_right && at_bottom) begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end else begin
                        state <= S_MASK;
                        if (at_right) begin
                            patch_x <= left_r;
                            patch_y <= patch_y + 4'd1;
                        end else begin
                            patch_x <= patch_x + 4'd1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/edge_mask.sv
// edge mask: one edge evaluated at the 16 samples of a 4x4 patch
`timescale 1ns/1ns
`default_nettype none

module edge_mask import raster_pkg::*; (
    input  edge_coef_t  a,
    input  edge_coef_t  b,
    input  edge_val_t   d,
    output patch_mask_t mask
);

    always_comb begin
        edge_val_t val;
        for (int i = 0; i < 16; i++) begin
            // col is i%4, row is i/4, offset from corner value d
            val = d + a * (i % 4) - b * (i / 4);
            // covered on zero or positive
            mask[15 - i] = ~val[31];
        end
    end

endmodule

`default_nettype wire

//--- hdl/edge_setup.sv
// edge setup: a, b and either c or the patch corner value from two multipliers
`timescale 1ns/1ns
`default_nettype none

module edge_setup import raster_pkg::*; (
    input  coord_t     corner_x,
    input  coord_t     corner_y,
    input  coord_t     x1,
    input  coord_t     y1,
    input  coord_t     x2,
    input  coord_t     y2,
    input  edge_val_t  c_in,
    input  logic       phase,
    output edge_coef_t a,
    output edge_coef_t b,
    output edge_val_t  cd
);

    // top-left style tie break
    logic       bias;
    edge_coef_t p;
    edge_coef_t r;
    coord_t     q;
    coord_t     s;
    edge_val_t  t;
    edge_val_t  prod_pq;
    edge_val_t  prod_rs;

    assign bias = (y1 < y2) || ((y1 == y2) && (x2 < x1));

    // line a*x - b*y + c, inside when not negative
    assign a = y2 - y1;
    assign b = x2 - x1;

    // phase low:  c = b*y1 - a*x1 - bias
    // phase high: d = a*cx - b*cy + c
    assign p = phase ? a : b;
    assign q = phase ? corner_x : y1;
    assign r = phase ? b : a;
    assign s = phase ? corner_y : x1;
    // all ones is minus one
    assign t = phase ? c_in : {32{bias}};

    // the two shared multipliers
    assign prod_pq = p * q;
    assign prod_rs = r * s;

    assign cd = prod_pq - prod_rs + t;

endmodule

`default_nettype wire

//--- hdl/bounding_box.sv
// bounding box: clamped min and max patch index of three vertices on one axis
`timescale 1ns/1ns
`default_nettype none

module bounding_box import raster_pkg::*; (
    input  tile_idx_t  tile,
    input  coord_t     v1,
    input  coord_t     v2,
    input  coord_t     v3,
    output patch_idx_t lo,
    output patch_idx_t hi
);

    // coordinates at patch resolution, 4 units per patch
    logic signed [13:0] p1;
    logic signed [13:0] p2;
    logic signed [13:0] p3;
    // first and last patch of the tile
    logic signed [13:0] tile_first;
    logic signed [13:0] tile_last;
    logic signed [13:0] pmin;
    logic signed [13:0] pmax;

    assign p1 = v1[15:2];
    assign p2 = v2[15:2];
    assign p3 = v3[15:2];

    assign tile_first = {tile, 4'b0000};
    assign tile_last  = {tile, 4'b1111};

    always_comb begin
        pmin = p1;
        if (p2 < pmin) pmin = p2;
        if (p3 < pmin) pmin = p3;
        // clamp into the tile
        if (pmin < tile_first) pmin = tile_first;
        if (pmin > tile_last) pmin = tile_last;

        pmax = p1;
        if (p2 > pmax) pmax = p2;
        if (p3 > pmax) pmax = p3;
        if (pmax < tile_first) pmax = tile_first;
        if (pmax > tile_last) pmax = tile_last;
    end

    // tile-relative offset, low bits of a clamped index
    assign lo = pmin[3:0];
    assign hi = pmax[3:0];

endmodule

`default_nettype wire

//--- hdl/raster_pkg.sv
// raster package: coordinate and edge types, bus widths and register map
`default_nettype none

package raster_pkg;

    // wishbone port widths
    localparam int ADR_W  = 5;
    localparam int DATA_W = 32;

    // vertex coordinate, integer screen units
    typedef logic signed [15:0] coord_t;
    // edge coefficients a and b
    typedef logic signed [15:0] edge_coef_t;
    // edge constant c and corner value d
    typedef logic signed [31:0] edge_val_t;
    // tile origin, coordinate bits 15 to 6
    typedef logic signed [9:0]  tile_idx_t;
    // patch column or row within the tile
    typedef logic [3:0]         patch_idx_t;
    // sample (col,row) at bit 15 - (row*4 + col)
    typedef logic [15:0]        patch_mask_t;

    // word address, bus address bits 4 to 2
    typedef logic [2:0] reg_addr_t;

    localparam reg_addr_t REG_TILE = 3'd0;
    localparam reg_addr_t REG_V1   = 3'd1;
    localparam reg_addr_t REG_V2   = 3'd2;
    localparam reg_addr_t REG_V3   = 3'd3;
    localparam reg_addr_t REG_CTRL = 3'd4;

    // status bits in a REG_CTRL read
    localparam int DONE_BIT  = 16;
    localparam int VALID_BIT = 17;

endpackage

`default_nettype wire
